// ==== roce_qp_state_top.f ====
+incdir+dv
src/roce_qp_pkg.sv
src/roce_qp_cmd_arbiter.sv
src/roce_qp_context_table.sv
src/roce_qp_context_reader.sv
src/roce_qp_state_top.sv
dv/roce_qp_state_tb.sv

// ==== Makefile ====
TOP := roce_qp_state_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): roce_qp_state_top.f src/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert --top-module $(TOP) -f roce_qp_state_top.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== dv/roce_qp_model.svh ====
`ifndef ROCE_QP_MODEL_SVH
`define ROCE_QP_MODEL_SVH

// Expected table contents, one entry per QP
roce_qp_pkg::qp_context_t model_ctx [roce_qp_pkg::NUM_QP];

function automatic bit qpn_ok(roce_qp_pkg::qpn_t qpn);
  return int'(qpn) >= roce_qp_pkg::QPN_BASE &&
         int'(qpn) < roce_qp_pkg::QPN_BASE + roce_qp_pkg::NUM_QP;
endfunction

function automatic roce_qp_pkg::qp_idx_t slot_of(roce_qp_pkg::qpn_t qpn);
  return roce_qp_pkg::qp_idx_t'(int'(qpn) - roce_qp_pkg::QPN_BASE);
endfunction

// One PSN per packet, packets are 256 << pmtu bytes with 4096 as the ceiling
function automatic roce_qp_pkg::psn_t psn_after_dma(roce_qp_pkg::psn_t psn,
                                                    logic [31:0] len, logic [2:0] pmtu);
  longint unsigned mtu;
  longint unsigned pkts;
  mtu  = 64'd256 << ((pmtu > 3'd4) ? 3'd4 : pmtu);
  pkts = (64'(len) + mtu - 64'd1) / mtu;
  return roce_qp_pkg::psn_t'(64'(psn) + pkts);
endfunction

// Applies the one command accepted from the inputs driven this cycle
// Returns 1 when an open must be refused
function automatic bit apply_inputs();
  roce_qp_pkg::qp_idx_t idx;
  bit                   fail;
  fail = 1'b0;
  if (qp_close_valid && qpn_ok(qp_close_loc_qpn)) begin
    idx = slot_of(qp_close_loc_qpn);
    model_ctx[idx].state    = roce_qp_pkg::QP_ERROR;
    model_ctx[idx].syndrome = roce_qp_pkg::SYND_CLOSE_ERR;
  end else if (rx_bth_valid && rx_aeth_valid && qpn_ok(rx_bth_dest_qp)) begin
    idx = slot_of(rx_bth_dest_qp);
    if (rx_bth_op_code == roce_qp_pkg::RC_RDMA_ACK && rx_aeth_syndrome[6:5] == 2'b11 &&
        rx_aeth_syndrome[4:0] != 5'd0) begin
      model_ctx[idx].state    = roce_qp_pkg::QP_ERROR;
      model_ctx[idx].syndrome = rx_aeth_syndrome;
    end
  end else if (meta_valid && qpn_ok(meta_loc_qpn)) begin
    idx = slot_of(meta_loc_qpn);
    model_ctx[idx].rem_psn  = psn_after_dma(meta_rem_psn, meta_dma_length, pmtu);
    model_ctx[idx].syndrome = 8'h00;
  end else if (qp_context_valid && qpn_ok(qp_init_loc_qpn)) begin
    idx = slot_of(qp_init_loc_qpn);
    if (!qp_init_open_qp) begin
      model_ctx[idx].state    = roce_qp_pkg::QP_RESET;
      model_ctx[idx].syndrome = 8'h00;
    end else if (model_ctx[idx].state != roce_qp_pkg::QP_RESET) begin
      fail = 1'b1;
    end else begin
      model_ctx[idx] = '{state: roce_qp_pkg::QP_RTS, syndrome: 8'h00,
                         rem_ip_addr: qp_init_rem_ip_addr, rem_qpn: qp_init_rem_qpn,
                         loc_qpn: qp_init_loc_qpn, rem_psn: qp_init_rem_psn,
                         loc_psn: qp_init_loc_psn, rem_addr: qp_init_rem_addr,
                         r_key: qp_init_r_key};
    end
  end
  return fail;
endfunction

`endif

// ==== dv/roce_qp_state_tb.sv ====
`default_nettype none

module roce_qp_state_tb;

  // 400 random operations of at most 6 cycles, directed part and reset
  localparam int unsigned MAX_CYCLES = 2500;

  logic                     clk;
  logic                     rst_qp;
  logic [2:0]               pmtu;
  logic                     qp_close_valid;
  roce_qp_pkg::qpn_t        qp_close_loc_qpn;
  logic                     rx_bth_valid;
  logic [7:0]               rx_bth_op_code;
  roce_qp_pkg::qpn_t        rx_bth_dest_qp;
  logic                     rx_aeth_valid;
  logic [7:0]               rx_aeth_syndrome;
  logic                     meta_valid;
  logic [31:0]              meta_dma_length;
  roce_qp_pkg::qpn_t        meta_loc_qpn;
  roce_qp_pkg::psn_t        meta_rem_psn;
  logic                     qp_context_valid;
  logic                     qp_init_open_qp;
  logic [31:0]              qp_init_r_key;
  roce_qp_pkg::qpn_t        qp_init_rem_qpn;
  roce_qp_pkg::qpn_t        qp_init_loc_qpn;
  roce_qp_pkg::psn_t        qp_init_rem_psn;
  roce_qp_pkg::psn_t        qp_init_loc_psn;
  logic [31:0]              qp_init_rem_ip_addr;
  logic [63:0]              qp_init_rem_addr;
  logic                     qp_context_req;
  roce_qp_pkg::qpn_t        qp_local_qpn_req;
  logic                     open_failed;
  logic                     ctx_valid;
  logic                     ctx_invalid;
  roce_qp_pkg::qp_state_e   ctx_state;
  logic [7:0]               ctx_syndrome;
  logic [31:0]              ctx_rem_ip_addr;
  roce_qp_pkg::qpn_t        ctx_rem_qpn;
  roce_qp_pkg::qpn_t        ctx_loc_qpn;
  roce_qp_pkg::psn_t        ctx_rem_psn;
  roce_qp_pkg::psn_t        ctx_loc_psn;
  logic [63:0]              ctx_rem_addr;
  logic [31:0]              ctx_r_key;
  int unsigned              cycles = 0;

  `include "roce_qp_model.svh"

  roce_qp_state_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_psn(string name, roce_qp_pkg::psn_t got, roce_qp_pkg::psn_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_context(roce_qp_pkg::qp_context_t exp);
    roce_qp_pkg::qp_context_t got;
    got = {ctx_state, ctx_syndrome, ctx_rem_ip_addr, ctx_rem_qpn, ctx_loc_qpn,
           ctx_rem_psn, ctx_loc_psn, ctx_rem_addr, ctx_r_key};
    check_psn("ctx_rem_psn", ctx_rem_psn, exp.rem_psn);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] ctx_state..ctx_r_key got %h expected %h", got, exp));
    end
  endtask

  task automatic idle_inputs();
    qp_close_valid   = 1'b0;
    rx_bth_valid     = 1'b0;
    rx_aeth_valid    = 1'b0;
    meta_valid       = 1'b0;
    qp_context_valid = 1'b0;
    qp_context_req   = 1'b0;
  endtask

  // About one in five is out of range, mostly just below or above the table
  function automatic roce_qp_pkg::qpn_t random_qpn();
    if ($urandom_range(4) == 0) begin
      if ($urandom_range(2) == 0) begin
        return roce_qp_pkg::qpn_t'($urandom);
      end
      return roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE - 1 +
                                 (roce_qp_pkg::NUM_QP + 1) * $urandom_range(1));
    end
    return roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE + $urandom_range(roce_qp_pkg::NUM_QP - 1));
  endfunction

  // Source 0 close, 1 BTH with AETH, 2 DMA metadata, 3 context command
  task automatic drive_source(int src, roce_qp_pkg::qpn_t qpn);
    case (src)
      0: begin
        qp_close_valid   = 1'b1;
        qp_close_loc_qpn = qpn;
      end
      1: begin
        rx_bth_valid     = 1'b1;
        rx_aeth_valid    = 1'b1;
        rx_bth_dest_qp   = qpn;
        rx_bth_op_code   = ($urandom_range(3) != 0) ? roce_qp_pkg::RC_RDMA_ACK : 8'($urandom);
        rx_aeth_syndrome = ($urandom_range(1) != 0) ? {1'($urandom), 2'b11, 5'($urandom)} :
                                                      8'($urandom);
      end
      2: begin
        meta_valid      = 1'b1;
        meta_loc_qpn    = qpn;
        meta_rem_psn    = 24'($urandom);
        meta_dma_length = ($urandom_range(1) != 0) ? 32'($urandom_range(20000)) : $urandom;
        pmtu            = 3'($urandom);
      end
      default: begin
        qp_context_valid    = 1'b1;
        qp_init_loc_qpn     = qpn;
        qp_init_open_qp     = ($urandom_range(2) != 0);
        qp_init_r_key       = $urandom;
        qp_init_rem_qpn     = 24'($urandom);
        qp_init_rem_psn     = 24'($urandom);
        qp_init_loc_psn     = 24'($urandom);
        qp_init_rem_ip_addr = $urandom;
        qp_init_rem_addr    = {$urandom, $urandom};
      end
    endcase
  endtask

  // Called on the falling edge that drove the command
  task automatic finish_command();
    bit exp_fail;
    exp_fail = apply_inputs();
    @(negedge clk);
    idle_inputs();
    @(negedge clk);
    check_flag("open_failed", open_failed, exp_fail);
  endtask

  task automatic read_qp(roce_qp_pkg::qpn_t qpn);
    bit ok;
    ok = qpn_ok(qpn);
    @(negedge clk);
    qp_context_req   = 1'b1;
    qp_local_qpn_req = qpn;
    @(negedge clk);
    qp_context_req = 1'b0;
    repeat (2) @(negedge clk);
    check_flag("ctx_valid", ctx_valid, ok);
    check_flag("ctx_invalid", ctx_invalid, !ok);
    if (ok) begin
      check_context(model_ctx[slot_of(qpn)]);
    end
  endtask

  initial begin
    void'($urandom(32'hc529_b9c8));
    rst_qp              = 1'b1;
    pmtu                = '0;
    qp_close_loc_qpn    = '0;
    rx_bth_op_code      = '0;
    rx_bth_dest_qp      = '0;
    rx_aeth_syndrome    = '0;
    meta_dma_length     = '0;
    meta_loc_qpn        = '0;
    meta_rem_psn        = '0;
    qp_init_open_qp     = 1'b0;
    qp_init_r_key       = '0;
    qp_init_rem_qpn     = '0;
    qp_init_loc_qpn     = '0;
    qp_init_rem_psn     = '0;
    qp_init_loc_psn     = '0;
    qp_init_rem_ip_addr = '0;
    qp_init_rem_addr    = '0;
    qp_local_qpn_req    = '0;
    idle_inputs();
    model_ctx = '{default: '0};
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_qp = 1'b0;
    check_flag("open_failed", open_failed, 1'b0);
    check_flag("ctx_valid", ctx_valid, 1'b0);
    check_flag("ctx_invalid", ctx_invalid, 1'b0);

    for (int i = 0; i < roce_qp_pkg::NUM_QP; i++) begin
      read_qp(roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE + i));
    end

    // Second open of each QP is refused
    for (int i = 0; i < roce_qp_pkg::NUM_QP; i++) begin
      repeat (2) begin
        @(negedge clk);
        drive_source(3, roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE + i));
        qp_init_open_qp = 1'b1;
        finish_command();
        read_qp(roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE + i));
      end
    end

    // Every PMTU code, the top three clamp to 4096
    for (int p = 0; p < 8; p++) begin
      @(negedge clk);
      drive_source(2, roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE));
      pmtu = 3'(p);
      finish_command();
      read_qp(roce_qp_pkg::qpn_t'(roce_qp_pkg::QPN_BASE));
    end

    repeat (400) begin
      if ($urandom_range(4) == 0) begin
        read_qp(random_qpn());
      end else begin
        @(negedge clk);
        drive_source($urandom_range(3), random_qpn());
        // Sometimes a second source in the same cycle
        if ($urandom_range(3) == 0) begin
          drive_source($urandom_range(3), random_qpn());
        end
        finish_command();
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/roce_qp_state_top.sv ====
`default_nettype none

module roce_qp_state_top (
  input  wire                      clk,
  input  wire                      rst_qp,
  input  wire [2:0]                pmtu,
  input  wire                      qp_close_valid,
  input  wire roce_qp_pkg::qpn_t   qp_close_loc_qpn,
  input  wire                      rx_bth_valid,
  input  wire [7:0]                rx_bth_op_code,
  input  wire roce_qp_pkg::qpn_t   rx_bth_dest_qp,
  input  wire                      rx_aeth_valid,
  input  wire [7:0]                rx_aeth_syndrome,
  input  wire                      meta_valid,
  input  wire [31:0]               meta_dma_length,
  input  wire roce_qp_pkg::qpn_t   meta_loc_qpn,
  input  wire roce_qp_pkg::psn_t   meta_rem_psn,
  input  wire                      qp_context_valid,
  input  wire                      qp_init_open_qp,
  input  wire [31:0]               qp_init_r_key,
  input  wire roce_qp_pkg::qpn_t   qp_init_rem_qpn,
  input  wire roce_qp_pkg::qpn_t   qp_init_loc_qpn,
  input  wire roce_qp_pkg::psn_t   qp_init_rem_psn,
  input  wire roce_qp_pkg::psn_t   qp_init_loc_psn,
  input  wire [31:0]               qp_init_rem_ip_addr,
  input  wire [63:0]               qp_init_rem_addr,
  input  wire                      qp_context_req,
  input  wire roce_qp_pkg::qpn_t   qp_local_qpn_req,
  output logic                     open_failed,
  output logic                     ctx_valid,
  output logic                     ctx_invalid,
  output roce_qp_pkg::qp_state_e   ctx_state,
  output logic [7:0]               ctx_syndrome,
  output logic [31:0]              ctx_rem_ip_addr,
  output roce_qp_pkg::qpn_t        ctx_rem_qpn,
  output roce_qp_pkg::qpn_t        ctx_loc_qpn,
  output roce_qp_pkg::psn_t        ctx_rem_psn,
  output roce_qp_pkg::psn_t        ctx_loc_psn,
  output logic [63:0]              ctx_rem_addr,
  output logic [31:0]              ctx_r_key
);

  roce_qp_pkg::qp_op_e      op_kind;
  roce_qp_pkg::qp_idx_t     op_idx;
  roce_qp_pkg::psn_t        op_rem_psn;
  logic [7:0]               op_syndrome;
  roce_qp_pkg::qp_context_t op_context;
  logic                     rd_en;
  roce_qp_pkg::qp_idx_t     rd_idx;
  roce_qp_pkg::qp_context_t rd_context;

  roce_qp_cmd_arbiter u_cmd_arbiter (
    .clk                 (clk),
    .rst_qp              (rst_qp),
    .pmtu                (pmtu),
    .qp_close_valid      (qp_close_valid),
    .qp_close_loc_qpn    (qp_close_loc_qpn),
    .rx_bth_valid        (rx_bth_valid),
    .rx_bth_op_code      (rx_bth_op_code),
    .rx_bth_dest_qp      (rx_bth_dest_qp),
    .rx_aeth_valid       (rx_aeth_valid),
    .rx_aeth_syndrome    (rx_aeth_syndrome),
    .meta_valid          (meta_valid),
    .meta_dma_length     (meta_dma_length),
    .meta_loc_qpn        (meta_loc_qpn),
    .meta_rem_psn        (meta_rem_psn),
    .qp_context_valid    (qp_context_valid),
    .qp_init_open_qp     (qp_init_open_qp),
    .qp_init_r_key       (qp_init_r_key),
    .qp_init_rem_qpn     (qp_init_rem_qpn),
    .qp_init_loc_qpn     (qp_init_loc_qpn),
    .qp_init_rem_psn     (qp_init_rem_psn),
    .qp_init_loc_psn     (qp_init_loc_psn),
    .qp_init_rem_ip_addr (qp_init_rem_ip_addr),
    .qp_init_rem_addr    (qp_init_rem_addr),
    .op_kind             (op_kind),
    .op_idx              (op_idx),
    .op_rem_psn          (op_rem_psn),
    .op_syndrome         (op_syndrome),
    .op_context          (op_context)
  );

  roce_qp_context_table u_context_table (
    .clk         (clk),
    .rst_qp      (rst_qp),
    .op_kind     (op_kind),
    .op_idx      (op_idx),
    .op_rem_psn  (op_rem_psn),
    .op_syndrome (op_syndrome),
    .op_context  (op_context),
    .rd_en       (rd_en),
    .rd_idx      (rd_idx),
    .rd_context  (rd_context),
    .open_failed (open_failed)
  );

  roce_qp_context_reader u_context_reader (
    .clk              (clk),
    .rst_qp           (rst_qp),
    .qp_context_req   (qp_context_req),
    .qp_local_qpn_req (qp_local_qpn_req),
    .rd_context       (rd_context),
    .rd_en            (rd_en),
    .rd_idx           (rd_idx),
    .ctx_valid        (ctx_valid),
    .ctx_invalid      (ctx_invalid),
    .ctx_state        (ctx_state),
    .ctx_syndrome     (ctx_syndrome),
    .ctx_rem_ip_addr  (ctx_rem_ip_addr),
    .ctx_rem_qpn      (ctx_rem_qpn),
    .ctx_loc_qpn      (ctx_loc_qpn),
    .ctx_rem_psn      (ctx_rem_psn),
    .ctx_loc_psn      (ctx_loc_psn),
    .ctx_rem_addr     (ctx_rem_addr),
    .ctx_r_key        (ctx_r_key)
  );

endmodule

`default_nettype wire

// ==== src/roce_qp_context_reader.sv ====
`default_nettype none

module roce_qp_context_reader (
  input  wire                              clk,
  input  wire                              rst_qp,
  input  wire                              qp_context_req,
  input  wire roce_qp_pkg::qpn_t           qp_local_qpn_req,
  input  wire roce_qp_pkg::qp_context_t    rd_context,
  output logic                             rd_en,
  output roce_qp_pkg::qp_idx_t             rd_idx,
  output logic                             ctx_valid,
  output logic                             ctx_invalid,
  output roce_qp_pkg::qp_state_e           ctx_state,
  output logic [7:0]                       ctx_syndrome,
  output logic [31:0]                      ctx_rem_ip_addr,
  output roce_qp_pkg::qpn_t                ctx_rem_qpn,
  output roce_qp_pkg::qpn_t                ctx_loc_qpn,
  output roce_qp_pkg::psn_t                ctx_rem_psn,
  output roce_qp_pkg::psn_t                ctx_loc_psn,
  output logic [63:0]                      ctx_rem_addr,
  output logic [31:0]                      ctx_r_key
);

  logic                     invalid_s1;
  logic                     valid_s2;
  logic                     invalid_s2;
  roce_qp_pkg::qp_context_t ctx_q;

  // Stage 1 issues the table read, stage 2 waits on the memory
  always_ff @(posedge clk) begin
    if (rst_qp) begin
      rd_en       <= 1'b0;
      invalid_s1  <= 1'b0;
      valid_s2    <= 1'b0;
      invalid_s2  <= 1'b0;
      ctx_valid   <= 1'b0;
      ctx_invalid <= 1'b0;
    end else begin
      rd_en       <= qp_context_req && roce_qp_pkg::qpn_in_range(qp_local_qpn_req);
      invalid_s1  <= qp_context_req && !roce_qp_pkg::qpn_in_range(qp_local_qpn_req);
      valid_s2    <= rd_en;
      invalid_s2  <= invalid_s1;
      ctx_valid   <= valid_s2;
      ctx_invalid <= invalid_s2;
    end
  end

  always_ff @(posedge clk) begin
    rd_idx <= roce_qp_pkg::qpn_to_idx(qp_local_qpn_req);
    if (valid_s2) begin
      ctx_q <= rd_context;
    end
  end

  assign ctx_state       = ctx_q.state;
  assign ctx_syndrome    = ctx_q.syndrome;
  assign ctx_rem_ip_addr = ctx_q.rem_ip_addr;
  assign ctx_rem_qpn     = ctx_q.rem_qpn;
  assign ctx_loc_qpn     = ctx_q.loc_qpn;
  assign ctx_rem_psn     = ctx_q.rem_psn;
  assign ctx_loc_psn     = ctx_q.loc_psn;
  assign ctx_rem_addr    = ctx_q.rem_addr;
  assign ctx_r_key       = ctx_q.r_key;

  // Each request answers with exactly one flag, never both
  assert property (@(posedge clk) disable iff (rst_qp)
    qp_context_req |-> ##3 $onehot({ctx_valid, ctx_invalid}));

  assert property (@(posedge clk) disable iff (rst_qp)
    $onehot0({ctx_valid, ctx_invalid}));

endmodule

`default_nettype wire

// ==== src/roce_qp_context_table.sv ====
`default_nettype none

module roce_qp_context_table (
  input  wire                              clk,
  input  wire                              rst_qp,
  input  wire roce_qp_pkg::qp_op_e         op_kind,
  input  wire roce_qp_pkg::qp_idx_t        op_idx,
  input  wire roce_qp_pkg::psn_t           op_rem_psn,
  input  wire [7:0]                        op_syndrome,
  input  wire roce_qp_pkg::qp_context_t    op_context,
  input  wire                              rd_en,
  input  wire roce_qp_pkg::qp_idx_t        rd_idx,
  output roce_qp_pkg::qp_context_t         rd_context,
  output logic                             open_failed
);

  roce_qp_pkg::qp_context_t ctx_mem [roce_qp_pkg::NUM_QP];
  roce_qp_pkg::qp_context_t cur_ctx;
  roce_qp_pkg::qp_context_t upd_ctx;
  logic                     wr_en;
  logic                     open_fail_nxt;

  // Read-modify-write of the addressed entry
  always_comb begin
    cur_ctx       = ctx_mem[op_idx];
    upd_ctx       = cur_ctx;
    wr_en         = 1'b0;
    open_fail_nxt = 1'b0;
    case (op_kind)
      roce_qp_pkg::OP_OPEN: begin
        // Only a QP in RESET may be opened
        if (cur_ctx.state == roce_qp_pkg::QP_RESET) begin
          upd_ctx          = op_context;
          upd_ctx.state    = roce_qp_pkg::QP_RTS;
          upd_ctx.syndrome = 8'd0;
          wr_en            = 1'b1;
        end else begin
          open_fail_nxt = 1'b1;
        end
      end
      roce_qp_pkg::OP_CLOSE: begin
        upd_ctx.state    = roce_qp_pkg::QP_RESET;
        upd_ctx.syndrome = 8'd0;
        wr_en            = 1'b1;
      end
      roce_qp_pkg::OP_ERROR: begin
        upd_ctx.state    = roce_qp_pkg::QP_ERROR;
        upd_ctx.syndrome = op_syndrome;
        wr_en            = 1'b1;
      end
      roce_qp_pkg::OP_UPDATE: begin
        upd_ctx.rem_psn  = op_rem_psn;
        upd_ctx.syndrome = 8'd0;
        wr_en            = 1'b1;
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      // All-zero context is the RESET state
      for (int i = 0; i < roce_qp_pkg::NUM_QP; i++) begin
        ctx_mem[i] <= '0;
      end
    end else if (wr_en) begin
      ctx_mem[op_idx] <= upd_ctx;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      open_failed <= 1'b0;
    end else begin
      open_failed <= open_fail_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_context <= ctx_mem[rd_idx];
    end
  end

  // A refused open leaves the entry as it was
  assert property (@(posedge clk) disable iff (rst_qp)
    open_failed |-> $past(op_kind) == roce_qp_pkg::OP_OPEN &&
                    ctx_mem[$past(op_idx)] == $past(cur_ctx));

endmodule

`default_nettype wire

// ==== src/roce_qp_cmd_arbiter.sv ====
`default_nettype none

module roce_qp_cmd_arbiter (
  input  wire                              clk,
  input  wire                              rst_qp,
  input  wire [2:0]                        pmtu,
  input  wire                              qp_close_valid,
  input  wire roce_qp_pkg::qpn_t           qp_close_loc_qpn,
  input  wire                              rx_bth_valid,
  input  wire [7:0]                        rx_bth_op_code,
  input  wire roce_qp_pkg::qpn_t           rx_bth_dest_qp,
  input  wire                              rx_aeth_valid,
  input  wire [7:0]                        rx_aeth_syndrome,
  input  wire                              meta_valid,
  input  wire [31:0]                       meta_dma_length,
  input  wire roce_qp_pkg::qpn_t           meta_loc_qpn,
  input  wire roce_qp_pkg::psn_t           meta_rem_psn,
  input  wire                              qp_context_valid,
  input  wire                              qp_init_open_qp,
  input  wire [31:0]                       qp_init_r_key,
  input  wire roce_qp_pkg::qpn_t           qp_init_rem_qpn,
  input  wire roce_qp_pkg::qpn_t           qp_init_loc_qpn,
  input  wire roce_qp_pkg::psn_t           qp_init_rem_psn,
  input  wire roce_qp_pkg::psn_t           qp_init_loc_psn,
  input  wire [31:0]                       qp_init_rem_ip_addr,
  input  wire [63:0]                       qp_init_rem_addr,
  output roce_qp_pkg::qp_op_e              op_kind,
  output roce_qp_pkg::qp_idx_t             op_idx,
  output roce_qp_pkg::psn_t                op_rem_psn,
  output logic [7:0]                       op_syndrome,
  output roce_qp_pkg::qp_context_t         op_context
);

  logic                     aeth_fatal;
  logic [2:0]               pmtu_eff;
  logic [4:0]               pkt_shift;
  logic [31:0]              len_mask;
  logic [31:0]              pkt_cnt;
  logic [31:0]              psn_sum;
  roce_qp_pkg::psn_t        new_psn;
  roce_qp_pkg::qp_op_e      nxt_kind;
  roce_qp_pkg::qp_idx_t     nxt_idx;
  logic [7:0]               nxt_syndrome;
  roce_qp_pkg::qp_context_t open_ctx;

  // NAK with a real error code, PSN sequence errors are not fatal
  assign aeth_fatal = (rx_bth_op_code == roce_qp_pkg::RC_RDMA_ACK) &&
                      (rx_aeth_syndrome[6:5] == 2'b11) &&
                      (rx_aeth_syndrome[4:0] != 5'd0);

  // Packet count is length over MTU, rounded up
  always_comb begin
    pmtu_eff  = (pmtu > roce_qp_pkg::PMTU_MAX) ? roce_qp_pkg::PMTU_MAX : pmtu;
    pkt_shift = roce_qp_pkg::PMTU_BASE_SHIFT + {2'b00, pmtu_eff};
    len_mask  = (32'd1 << pkt_shift) - 32'd1;
    pkt_cnt   = (meta_dma_length >> pkt_shift) + {31'd0, |(meta_dma_length & len_mask)};
    psn_sum   = {8'd0, meta_rem_psn} + pkt_cnt;
    new_psn   = psn_sum[23:0];
  end

  always_comb begin
    open_ctx             = '0;
    open_ctx.state       = roce_qp_pkg::QP_RESET;
    open_ctx.rem_ip_addr = qp_init_rem_ip_addr;
    open_ctx.rem_qpn     = qp_init_rem_qpn;
    open_ctx.loc_qpn     = qp_init_loc_qpn;
    open_ctx.rem_psn     = qp_init_rem_psn;
    open_ctx.loc_psn     = qp_init_loc_psn;
    open_ctx.rem_addr    = qp_init_rem_addr;
    open_ctx.r_key       = qp_init_r_key;
  end

  // Fixed priority, one command per cycle
  always_comb begin
    nxt_kind     = roce_qp_pkg::OP_NONE;
    nxt_idx      = '0;
    nxt_syndrome = 8'd0;
    if (qp_close_valid && roce_qp_pkg::qpn_in_range(qp_close_loc_qpn)) begin
      nxt_kind     = roce_qp_pkg::OP_ERROR;
      nxt_idx      = roce_qp_pkg::qpn_to_idx(qp_close_loc_qpn);
      nxt_syndrome = roce_qp_pkg::SYND_CLOSE_ERR;
    end else if (rx_bth_valid && rx_aeth_valid &&
                 roce_qp_pkg::qpn_in_range(rx_bth_dest_qp)) begin
      // Plain ACKs still occupy the slot
      if (aeth_fatal) begin
        nxt_kind     = roce_qp_pkg::OP_ERROR;
        nxt_idx      = roce_qp_pkg::qpn_to_idx(rx_bth_dest_qp);
        nxt_syndrome = rx_aeth_syndrome;
      end
    end else if (meta_valid && roce_qp_pkg::qpn_in_range(meta_loc_qpn)) begin
      nxt_kind = roce_qp_pkg::OP_UPDATE;
      nxt_idx  = roce_qp_pkg::qpn_to_idx(meta_loc_qpn);
    end else if (qp_context_valid && roce_qp_pkg::qpn_in_range(qp_init_loc_qpn)) begin
      nxt_kind = qp_init_open_qp ? roce_qp_pkg::OP_OPEN : roce_qp_pkg::OP_CLOSE;
      nxt_idx  = roce_qp_pkg::qpn_to_idx(qp_init_loc_qpn);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_qp) begin
      op_kind <= roce_qp_pkg::OP_NONE;
    end else begin
      op_kind <= nxt_kind;
    end
  end

  always_ff @(posedge clk) begin
    if (nxt_kind != roce_qp_pkg::OP_NONE) begin
      op_idx      <= nxt_idx;
      op_rem_psn  <= new_psn;
      op_syndrome <= nxt_syndrome;
    end
    if (nxt_kind == roce_qp_pkg::OP_OPEN) begin
      op_context <= open_ctx;
    end
  end

  // Oversized PMTU codes fall back to 4096 byte packets
  assert property (@(posedge clk) disable iff (rst_qp)
    (op_kind == roce_qp_pkg::OP_UPDATE && $past(pmtu) > roce_qp_pkg::PMTU_MAX) |->
      op_rem_psn == $past(meta_rem_psn +
                          roce_qp_pkg::psn_t'((33'(meta_dma_length) + 33'd4095) >> 12)));

endmodule

`default_nettype wire

// ==== src/roce_qp_pkg.sv ====
`default_nettype none

package roce_qp_pkg;

  localparam int NUM_QP   = 4;
  localparam int QP_IDX_W = $clog2(NUM_QP);
  localparam int QPN_BASE = 256;

  // Path MTU codes, 0 is 256 bytes and 4 is 4096 bytes
  localparam logic [2:0] PMTU_MAX        = 3'd4;
  localparam logic [4:0] PMTU_BASE_SHIFT = 5'd8;

  localparam logic [7:0] RC_RDMA_ACK    = 8'h11;
  localparam logic [7:0] SYND_CLOSE_ERR = 8'h9F;

  typedef logic [23:0]         qpn_t;
  typedef logic [23:0]         psn_t;
  typedef logic [QP_IDX_W-1:0] qp_idx_t;

  typedef enum logic [2:0] {
    QP_RESET    = 3'd0,
    QP_INIT     = 3'd1,
    QP_RTR      = 3'd2,
    QP_RTS      = 3'd3,
    QP_SQ_DRAIN = 3'd4,
    QP_SQ_ERROR = 3'd5,
    QP_ERROR    = 3'd6
  } qp_state_e;

  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_OPEN   = 3'd1,
    OP_CLOSE  = 3'd2,
    OP_ERROR  = 3'd3,
    OP_UPDATE = 3'd4
  } qp_op_e;

  typedef struct packed {
    qp_state_e   state;
    logic [7:0]  syndrome;
    logic [31:0] rem_ip_addr;
    qpn_t        rem_qpn;
    qpn_t        loc_qpn;
    psn_t        rem_psn;
    psn_t        loc_psn;
    logic [63:0] rem_addr;
    logic [31:0] r_key;
  } qp_context_t;

  // Local QPNs map onto the table from QPN_BASE upwards
  function automatic logic qpn_in_range(qpn_t qpn);
    return (qpn >= qpn_t'(QPN_BASE)) && (qpn < qpn_t'(QPN_BASE + NUM_QP));
  endfunction

  function automatic qp_idx_t qpn_to_idx(qpn_t qpn);
    qpn_t offset;
    offset = qpn - qpn_t'(QPN_BASE);
    return offset[QP_IDX_W-1:0];
  endfunction

endpackage

`default_nettype wire
